// ==== common/kotku_pkg.sv ====
// ================================================
// I/O map uses 21-bit decode {tga, byte address}
// ================================================
package kotku_pkg;

  // Bus widths
  localparam int DAT_W = 16;
  localparam int ADR_W = 19;   // Word address, bits 19 to 1
  localparam int DEC_W = 21;   // I/O tag + byte address

  // Board side widths
  localparam int SW_W       = 8;
  localparam int LED_W      = 16;
  localparam int POST_W     = 8;
  localparam int NUM_DIGITS = 8;

  // Address map, tag in bit 20
  localparam logic [DEC_W-1:0] POST_ADDR = 21'h1_00080;  // io 0x80
  localparam logic [DEC_W-1:0] POST_MASK = 21'h1_FFFFF;
  localparam logic [DEC_W-1:0] GPIO_ADDR = 21'h1_0F100;  // io 0xf100 - 0xf103
  localparam logic [DEC_W-1:0] GPIO_MASK = 21'h1_0FFFC;

  localparam logic [DAT_W-1:0] UNMAPPED_DATA = '1;  // Floating bus reads as ones

  typedef enum logic [1:0] {
    SLV_POST,
    SLV_GPIO,
    SLV_NONE
  } slave_e;

  typedef logic [6:0] seg_t;  // Active low, segment a in bit 0
  typedef seg_t [NUM_DIGITS-1:0] seg_bus_t;

endpackage

// ==== common/wb_if.sv ====
// ================================================
// Wishbone classic, no tags beyond tga
// ================================================
`timescale 1ns/1ps

interface wb_if
  import kotku_pkg::*;
();

  logic [ADR_W:1]   adr;
  logic             tga;    // High for I/O space
  logic [DAT_W-1:0] dat_w;
  logic [DAT_W-1:0] dat_r;
  logic [1:0]       sel;
  logic             we;
  logic             stb;
  logic             cyc;
  logic             ack;

  modport master (
    output adr, tga, dat_w, sel, we, stb, cyc,
    input  dat_r, ack
  );

  modport slave (
    input  adr, tga, dat_w, sel, we, stb, cyc,
    output dat_r, ack
  );

endinterface

// ==== io_switch/io_switch.sv ====
// ================================================
// First match wins; unmapped cycles ack in 1 cycle
// ================================================
`timescale 1ns/1ps

module io_switch
  import kotku_pkg::*;
#(
  parameter logic [DEC_W-1:0] POST_ADDR = kotku_pkg::POST_ADDR,
  parameter logic [DEC_W-1:0] POST_MASK = kotku_pkg::POST_MASK,
  parameter logic [DEC_W-1:0] GPIO_ADDR = kotku_pkg::GPIO_ADDR,
  parameter logic [DEC_W-1:0] GPIO_MASK = kotku_pkg::GPIO_MASK
) (
  input  logic             wb_clk_i,
  input  logic             rst_i,

  // From the bus master
  input  logic [ADR_W:1]   adr_i,
  input  logic             tga_i,
  input  logic [DAT_W-1:0] dat_i,
  input  logic [1:0]       sel_i,
  input  logic             we_i,
  input  logic             stb_i,
  input  logic             cyc_i,
  output logic [DAT_W-1:0] dat_o,
  output logic             ack_o,

  wb_if.master             post_bus,
  wb_if.master             gpio_bus
);

  logic [DEC_W-1:0] dec_adr;
  slave_e           target;
  logic             cyc_act;
  logic             none_ack;

  assign dec_adr = {tga_i, adr_i, 1'b0};  // Byte address, bit 0 always zero
  assign cyc_act = stb_i & cyc_i;

  // Address decoder
  always_comb begin
    if ((dec_adr & POST_MASK) == (POST_ADDR & POST_MASK)) begin
      target = SLV_POST;
    end else if ((dec_adr & GPIO_MASK) == (GPIO_ADDR & GPIO_MASK)) begin
      target = SLV_GPIO;
    end else begin
      target = SLV_NONE;
    end
  end

  // Shared lines go to both slaves
  assign post_bus.adr   = adr_i;
  assign post_bus.tga   = tga_i;
  assign post_bus.dat_w = dat_i;
  assign post_bus.sel   = sel_i;
  assign post_bus.we    = we_i;
  assign post_bus.stb   = stb_i & (target == SLV_POST);
  assign post_bus.cyc   = cyc_i & (target == SLV_POST);

  assign gpio_bus.adr   = adr_i;
  assign gpio_bus.tga   = tga_i;
  assign gpio_bus.dat_w = dat_i;
  assign gpio_bus.sel   = sel_i;
  assign gpio_bus.we    = we_i;
  assign gpio_bus.stb   = stb_i & (target == SLV_GPIO);
  assign gpio_bus.cyc   = cyc_i & (target == SLV_GPIO);

  // Default slave, keeps stray accesses from hanging the master
  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      none_ack <= 1'b0;
    end else begin
      none_ack <= cyc_act & (target == SLV_NONE) & ~none_ack;
    end
  end

  // Return path
  always_comb begin
    case (target)
      SLV_POST: begin
        dat_o = post_bus.dat_r;
        ack_o = post_bus.ack;
      end
      SLV_GPIO: begin
        dat_o = gpio_bus.dat_r;
        ack_o = gpio_bus.ack;
      end
      default: begin
        dat_o = UNMAPPED_DATA;
        ack_o = none_ack;
      end
    endcase
  end

endmodule

// ==== kotku.f ====
common/kotku_pkg.sv
common/wb_if.sv
io_switch/io_switch.sv
src/post_port.sv
src/gpio_port.sv
src/hex_display.sv
src/kotku_io.sv
verification/tb_kotku_io.sv

// ==== src/gpio_port.sv ====
// ================================================
// Switches sampled once, not debounced
// ================================================
`timescale 1ns/1ps

module gpio_port
  import kotku_pkg::*;
(
  input  logic             wb_clk_i,
  input  logic             rst_i,
  input  logic [SW_W-1:0]  sw_i,

  wb_if.slave              bus,

  output logic [LED_W-1:0] leds_o
);

  logic [SW_W-1:0]  sw_q;
  logic [LED_W-1:0] led_q;
  logic             ack_q;
  logic             req;
  logic             led_sel;

  assign req     = bus.stb & bus.cyc & ~ack_q;
  assign led_sel = bus.adr[1];  // 0xf102 is the LED word

  // Input register on the switches
  always_ff @(posedge wb_clk_i) begin
    sw_q <= sw_i;
  end

  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      ack_q <= 1'b0;
      led_q <= '0;
    end else begin
      ack_q <= req;
      // Switch word writes fall through here
      if (req && bus.we && led_sel) begin
        if (bus.sel[0]) begin
          led_q[7:0] <= bus.dat_w[7:0];
        end
        if (bus.sel[1]) begin
          led_q[LED_W-1:8] <= bus.dat_w[LED_W-1:8];
        end
      end
    end
  end

  always_comb begin
    if (led_sel) begin
      bus.dat_r = DAT_W'(led_q);
    end else begin
      bus.dat_r = {{(DAT_W-SW_W){1'b0}}, sw_q};  // Zero extended
    end
  end

  assign bus.ack = ack_q;
  assign leds_o  = led_q;

endmodule

// ==== src/hex_display.sv ====
// ================================================
// Common anode digits; digits 5 and 4 stay dark
// ================================================
`timescale 1ns/1ps

module hex_display
  import kotku_pkg::*;
(
  input  logic [POST_W-1:0] postcode_i,
  input  logic [LED_W-1:0]  leds_i,
  output seg_bus_t          hex_o
);

  localparam seg_t SEG_BLANK = 7'b111_1111;

  // Nibble to g..a pattern
  function automatic seg_t seg_decode(input logic [3:0] nib);
    case (nib)
      4'h0:    seg_decode = 7'b100_0000;
      4'h1:    seg_decode = 7'b111_1001;
      4'h2:    seg_decode = 7'b010_0100;
      4'h3:    seg_decode = 7'b011_0000;
      4'h4:    seg_decode = 7'b001_1001;
      4'h5:    seg_decode = 7'b001_0010;
      4'h6:    seg_decode = 7'b000_0010;
      4'h7:    seg_decode = 7'b111_1000;
      4'h8:    seg_decode = 7'b000_0000;
      4'h9:    seg_decode = 7'b001_0000;
      4'ha:    seg_decode = 7'b000_1000;
      4'hb:    seg_decode = 7'b000_0011;  // Lower case b
      4'hc:    seg_decode = 7'b100_0110;
      4'hd:    seg_decode = 7'b010_0001;  // Lower case d
      4'he:    seg_decode = 7'b000_0110;
      default: seg_decode = 7'b000_1110;
    endcase
  endfunction

  always_comb begin
    for (int i = 0; i < NUM_DIGITS; i++) begin
      hex_o[i] = SEG_BLANK;
    end
    // LED word on the low four digits
    for (int i = 0; i < LED_W/4; i++) begin
      hex_o[i] = seg_decode(leds_i[4*i +: 4]);
    end
    hex_o[NUM_DIGITS-1] = seg_decode(postcode_i[7:4]);
    hex_o[NUM_DIGITS-2] = seg_decode(postcode_i[3:0]);
  end

endmodule

// ==== src/kotku_io.sv ====
// ================================================
// Bus master lives outside; single clock wb_clk_i
// ================================================
`timescale 1ns/1ps

module kotku_io
  import kotku_pkg::*;
(
  input  logic             wb_clk_i,
  input  logic             rst_i,

  // Wishbone slave port for the external master
  input  logic [ADR_W:1]   wb_adr_i,
  input  logic             wb_tga_i,
  input  logic [DAT_W-1:0] wb_dat_i,
  input  logic [1:0]       wb_sel_i,
  input  logic             wb_we_i,
  input  logic             wb_stb_i,
  input  logic             wb_cyc_i,
  output logic [DAT_W-1:0] wb_dat_o,
  output logic             wb_ack_o,

  // Board I/O
  input  logic [SW_W-1:0]  sw_i,
  output logic [LED_W-1:0] ledr_o,
  output seg_bus_t         hex_o
);

  logic [POST_W-1:0] postcode;

  wb_if post_bus ();
  wb_if gpio_bus ();

  io_switch #(
    .POST_ADDR (POST_ADDR),
    .POST_MASK (POST_MASK),
    .GPIO_ADDR (GPIO_ADDR),
    .GPIO_MASK (GPIO_MASK)
  ) i_io_switch (
    .wb_clk_i (wb_clk_i),
    .rst_i    (rst_i),
    .adr_i    (wb_adr_i),
    .tga_i    (wb_tga_i),
    .dat_i    (wb_dat_i),
    .sel_i    (wb_sel_i),
    .we_i     (wb_we_i),
    .stb_i    (wb_stb_i),
    .cyc_i    (wb_cyc_i),
    .dat_o    (wb_dat_o),
    .ack_o    (wb_ack_o),
    .post_bus (post_bus.master),
    .gpio_bus (gpio_bus.master)
  );

  post_port i_post_port (
    .wb_clk_i   (wb_clk_i),
    .rst_i      (rst_i),
    .bus        (post_bus.slave),
    .postcode_o (postcode)
  );

  gpio_port i_gpio_port (
    .wb_clk_i (wb_clk_i),
    .rst_i    (rst_i),
    .sw_i     (sw_i),
    .bus      (gpio_bus.slave),
    .leds_o   (ledr_o)
  );

  hex_display i_hex_display (
    .postcode_i (postcode),
    .leds_i     (ledr_o),   // Mirrors the LED register
    .hex_o      (hex_o)
  );

endmodule

// ==== src/post_port.sv ====
// ================================================
// Only the low byte lane holds the code
// ================================================
`timescale 1ns/1ps

module post_port
  import kotku_pkg::*;
(
  input  logic              wb_clk_i,
  input  logic              rst_i,

  wb_if.slave               bus,

  output logic [POST_W-1:0] postcode_o
);

  logic              req;
  logic              ack_q;
  logic [POST_W-1:0] code_q;

  assign req = bus.stb & bus.cyc & ~ack_q;  // Back-to-back stb restarts after ack

  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      ack_q  <= 1'b0;
      code_q <= '0;
    end else begin
      ack_q <= req;
      if (req && bus.we && bus.sel[0]) begin
        code_q <= bus.dat_w[POST_W-1:0];
      end
    end
  end

  assign bus.ack    = ack_q;
  assign bus.dat_r  = {{(DAT_W-POST_W){1'b0}}, code_q};
  assign postcode_o = code_q;

endmodule

// ==== verification/tb_kotku_io.sv ====
// ================================================
// Bus inputs driven on the falling edge of wb_clk_i
// Address 0x81 shares a word with 0x80, so 0x82 is the unmapped port
// ================================================
`timescale 1ns/1ps

module tb_kotku_io
  import kotku_pkg::*;
();

  localparam int          EST_CYCLES = 600;                 // Rough length of all tests
  localparam int          MAX_CYCLES = 3 * EST_CYCLES + 200;
  localparam int unsigned RAND_SEED  = 32'h756d_1feb;
  localparam seg_t        SEG_BLANK  = 7'h7f;
  localparam seg_t        SEG_TABLE [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12,
                                             7'h02, 7'h78, 7'h00, 7'h10, 7'h08, 7'h03,
                                             7'h46, 7'h21, 7'h06, 7'h0e};

  logic             wb_clk_i;
  logic             rst_i;
  logic [ADR_W:1]   wb_adr_i;
  logic             wb_tga_i;
  logic [DAT_W-1:0] wb_dat_i;
  logic [1:0]       wb_sel_i;
  logic             wb_we_i;
  logic             wb_stb_i;
  logic             wb_cyc_i;
  logic [SW_W-1:0]  sw_i;
  logic [DAT_W-1:0] wb_dat_o;
  logic             wb_ack_o;
  logic [LED_W-1:0] ledr_o;
  seg_bus_t         hex_o;

  int                errors;
  int                tests_run;
  int                tests_failed;
  int                cycles;
  int unsigned       seed_val;
  logic [POST_W-1:0] post_model;
  logic [LED_W-1:0]  led_model;

  kotku_io i_kotku_io (.*);

  always #50 wb_clk_i = ~wb_clk_i;

  // Watchdog
  always @(posedge wb_clk_i) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: tests did not finish");
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic seg_bus_t expected_hex(input logic [POST_W-1:0] post,
                                            input logic [LED_W-1:0] leds);
    seg_bus_t h;
    h[7] = SEG_TABLE[post[7:4]];
    h[6] = SEG_TABLE[post[3:0]];
    h[5] = SEG_BLANK;
    h[4] = SEG_BLANK;
    for (int i = 0; i < 4; i++) begin
      h[i] = SEG_TABLE[leds[4*i +: 4]];
    end
    return h;
  endfunction

  function automatic logic [DAT_W-1:0] merge_bytes(input logic [DAT_W-1:0] old_val,
                                                   input logic [DAT_W-1:0] new_val,
                                                   input logic [1:0] sel);
    logic [DAT_W-1:0] r;
    r = old_val;
    if (sel[0]) r[7:0] = new_val[7:0];
    if (sel[1]) r[15:8] = new_val[15:8];
    return r;
  endfunction

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    assert (got === exp) else begin
      $display("** Error at %0t ns: %s: got %0h, expected %0h", $time, what, got, exp);
      errors++;
    end
  endtask

  // One Wishbone classic cycle, ack expected at the first falling edge
  task automatic bus_cycle(input logic io, input logic [19:0] badr, input logic we,
                           input logic [1:0] sel, input logic [DAT_W-1:0] wdat,
                           output logic [DAT_W-1:0] rdat);
    int waited;
    waited   = 0;
    wb_tga_i = io;
    wb_adr_i = badr[19:1];
    wb_we_i  = we;
    wb_sel_i = sel;
    wb_dat_i = wdat;
    wb_stb_i = 1'b1;
    wb_cyc_i = 1'b1;
    do begin
      @(negedge wb_clk_i);
      waited++;
    end while (!wb_ack_o && waited < 4);
    assert (waited == 1 && wb_ack_o) else begin
      $display("bus cycle to address %h was not acked one cycle after stb (waited %0d)",
               badr, waited);
      errors++;
    end
    rdat     = wb_dat_o;
    wb_stb_i = 1'b0;
    wb_cyc_i = 1'b0;
    wb_we_i  = 1'b0;
    @(negedge wb_clk_i);  // Idle cycle between transfers
    check_eq(wb_ack_o, 1'b0, "ack held past one cycle");
  endtask

  task automatic bus_write(input logic io, input logic [19:0] badr, input logic [1:0] sel,
                           input logic [DAT_W-1:0] wdat);
    logic [DAT_W-1:0] unused;
    bus_cycle(io, badr, 1'b1, sel, wdat, unused);
  endtask

  task automatic bus_read(input logic io, input logic [19:0] badr,
                          output logic [DAT_W-1:0] rdat);
    bus_cycle(io, badr, 1'b0, 2'b11, '0, rdat);
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (errors > errors_before) begin
      tests_failed++;
      $display("%s: FAILED with %0d errors", name, errors - errors_before);
    end else begin
      $display("%s: ok", name);
    end
  endtask

  task automatic check_outputs(input string what);
    check_eq(ledr_o, led_model, {what, " ledr_o"});
    check_eq(hex_o, expected_hex(post_model, led_model), {what, " hex_o"});
  endtask

  task automatic test_reset_state();
    int e0;
    e0 = errors;
    check_eq(wb_ack_o, 1'b0, "ack after reset");
    check_outputs("reset");
    finish_test("reset_state", e0);
  endtask

  task automatic test_post_code();
    int               e0;
    logic [DAT_W-1:0] rd;
    e0 = errors;
    bus_write(1'b1, 20'h00080, 2'b01, 16'h5a3c);
    post_model = 8'h3c;
    bus_read(1'b1, 20'h00080, rd);
    check_eq(rd, 16'h003c, "post read back");
    check_outputs("post write");
    bus_write(1'b1, 20'h00080, 2'b10, 16'h00ff);  // Low lane off, no change
    bus_read(1'b1, 20'h00080, rd);
    check_eq(rd, 16'h003c, "post after high lane write");
    check_outputs("post high lane");
    finish_test("post_code", e0);
  endtask

  task automatic test_switches();
    int               e0;
    logic [DAT_W-1:0] rd;
    logic [SW_W-1:0]  sw;
    e0 = errors;
    repeat (5) begin
      sw   = $urandom;
      sw_i = sw;
      repeat (2) @(negedge wb_clk_i);
      bus_read(1'b1, 20'h0f100, rd);
      check_eq(rd, {8'h00, sw}, "switch word");
    end
    finish_test("switches", e0);
  endtask

  task automatic test_led_register();
    int               e0;
    logic [DAT_W-1:0] rd;
    logic [DAT_W-1:0] wd;
    e0 = errors;
    for (int s = 0; s < 4; s++) begin
      wd = $urandom;
      bus_write(1'b1, 20'h0f102, s[1:0], wd);
      led_model = merge_bytes(led_model, wd, s[1:0]);
      check_outputs("led write");
      bus_read(1'b1, 20'h0f102, rd);
      check_eq(rd, led_model, "led read back");
    end
    finish_test("led_register", e0);
  endtask

  task automatic test_unmapped();
    int               e0;
    logic [DAT_W-1:0] rd;
    e0 = errors;
    bus_read(1'b0, 20'h00000, rd);  // Memory space
    check_eq(rd, 16'hffff, "memory 0x00000 read");
    bus_read(1'b1, 20'h00082, rd);
    check_eq(rd, 16'hffff, "io 0x82 read");
    bus_write(1'b1, 20'h00082, 2'b11, 16'h1234);
    bus_write(1'b0, 20'h00080, 2'b11, 16'h5678);  // Right address, wrong space
    bus_write(1'b0, 20'h0f102, 2'b11, 16'h9abc);
    check_outputs("unmapped write");
    finish_test("unmapped", e0);
  endtask

  task automatic test_random_mix();
    int               e0;
    int unsigned      kind;
    logic [DAT_W-1:0] rd;
    logic [DAT_W-1:0] wd;
    logic [1:0]       sel;
    e0 = errors;
    repeat (40) begin
      kind = $urandom_range(3, 0);
      wd   = $urandom;
      sel  = $urandom;
      case (kind)
        0: begin
          bus_write(1'b1, 20'h00080, sel, wd);
          if (sel[0]) post_model = wd[7:0];
        end
        1: begin
          bus_read(1'b1, 20'h00080, rd);
          check_eq(rd, {8'h00, post_model}, "random post read");
        end
        2: begin
          bus_write(1'b1, 20'h0f102, sel, wd);
          led_model = merge_bytes(led_model, wd, sel);
        end
        default: begin
          bus_read(1'b1, 20'h0f102, rd);
          check_eq(rd, led_model, "random led read");
        end
      endcase
      check_outputs("random mix");
    end
    finish_test("random_mix", e0);
  endtask

  initial begin
    seed_val     = $urandom(RAND_SEED);
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    cycles       = 0;
    post_model   = '0;
    led_model    = '0;
    wb_clk_i     = 1'b0;
    rst_i        = 1'b1;
    wb_adr_i     = '0;
    wb_tga_i     = 1'b0;
    wb_dat_i     = '0;
    wb_sel_i     = 2'b00;
    wb_we_i      = 1'b0;
    wb_stb_i     = 1'b0;
    wb_cyc_i     = 1'b0;
    sw_i         = '0;
    repeat (16) @(negedge wb_clk_i);
    rst_i = 1'b0;
    @(negedge wb_clk_i);

    test_reset_state();
    test_post_code();
    test_switches();
    test_led_register();
    test_unmapped();
    test_random_mix();

    $display("tests run: %0d, tests failed: %0d, check errors: %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
